//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_uart_top -f tb.f -o sim_uart
	./obj_dir/sim_uart +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "Test failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" sim.log; then echo "Run ended without a verdict"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- tb.f
uart_pkg.sv
uart_byte_if.sv
uart_hello.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_top_sva.sv
uart_checker.sv
tb_uart_top.sv

//--- tb_uart_top.sv
`timescale 1ns/1ps

module tb_uart_top;
  import uart_pkg::*;

  logic                 clock;
  logic                 arst_n;
  logic                 serial;
  logic [7:0]           data;
  logic                 valid;
  logic                 done;
  logic [sum_width-1:0] sum;
  logic                 end_of_test;
  logic                 reported;
  logic                 loaded;       // Data file read.
  int                   errors;
  int                   abort_cnt;    // Resets before the full run.
  int                   run;
  int                   got;          // Bytes received in this run.
  longint               watchdog_ns;
  logic [31:0]          file_mem [0:15];

  uart_top uart_top_inst (
    .clock    (clock),
    .i_arst_n (arst_n),
    .o_serial (serial),
    .o_data   (data),
    .o_valid  (valid),
    .o_done   (done),
    .o_sum    (sum)
  );

  uart_checker check_inst (
    .clock      (clock),
    .i_arst_n   (arst_n),
    .i_serial   (serial),
    .i_data     (data),
    .i_valid    (valid),
    .i_done     (done),
    .i_sum      (sum),
    .i_finish   (end_of_test),
    .o_errors   (errors),
    .o_reported (reported)
  );

  // ****************************************
  // Clock and watchdog
  // ****************************************
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // 8 ns period.
  end

  initial begin
    wait (loaded);
    watchdog_ns = longint'(abort_cnt + 1) * msg_len * 10 * cycles_per_bit * 8 * 2
                + longint'(abort_cnt + 1) * 8 * 8;  // Frames twice over, plus resets.
    #(watchdog_ns);
    $display("Watchdog expired at %0d ns before the last run completed", $time);
    $display("FAIL: see errors above");
    $finish;
  end

  // ****************************************
  // Reset sequence and aborts
  // ****************************************
  initial begin
    arst_n      <= 1'b0;
    end_of_test <= 1'b0;
    loaded = 1'b0;
    $readmemh("uart_input.txt", file_mem);
    abort_cnt = int'(file_mem[msg_len + 1]);
    loaded = 1'b1;
    repeat (8) @(posedge clock);
    arst_n <= 1'b1;
    for (run = 0; run < abort_cnt; run++) begin
      got = 0;
      while (got < int'(file_mem[msg_len + 2 + run])) begin
        @(negedge clock);
        if (valid) got++;
      end
      @(posedge clock);
      arst_n <= 1'b0;  // Mid-message abort.
      repeat (8) @(posedge clock);
      arst_n <= 1'b1;
    end
    while (!done) @(negedge clock);  // Last run goes to completion.
    repeat (20) @(posedge clock);    // Done holds with an idle line.
    end_of_test <= 1'b1;
    wait (reported);
    if (errors == 0 && uart_top_inst.sva_inst.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      if (uart_top_inst.sva_inst.fail_count != 0) begin
        $display("%0d assertion failures", uart_top_inst.sva_inst.fail_count);
      end
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- uart_byte_if.sv
`timescale 1ns/1ps

// Byte handoff between message source and transmitter.
interface uart_byte_if;
  logic [7:0] data;  // Byte offered by the source.
  logic       req;   // Source has a byte.
  logic       cts;   // Transmitter takes a byte.
  logic       idle;  // Transmitter between frames.

  modport source (
    output data,
    output req,
    input  cts,
    input  idle
  );

  modport sink (
    input  data,
    input  req,
    output cts,
    output idle
  );
endinterface

//--- uart_checker.sv
`timescale 1ns/1ps

module uart_checker (
  input  logic                           clock,
  input  logic                           i_arst_n,
  input  logic                           i_serial,
  input  logic [7:0]                     i_data,
  input  logic                           i_valid,
  input  logic                           i_done,
  input  logic [uart_pkg::sum_width-1:0] i_sum,
  input  logic                           i_finish,
  output int                             o_errors,
  output logic                           o_reported
);
  import uart_pkg::*;

  logic [31:0]          file_mem [0:15];    // Bytes, sum, abort list.
  logic [sum_width-1:0] exp_sum = '0;       // Sum of bytes seen this run.
  int                   idx = 0;            // Next expected byte.
  int                   test_num = 0;
  int                   test_errors = 0;
  int                   checks = 0;
  int                   errors = 0;
  logic                 run_active = 1'b0;  // Out of reset, no verdict yet.
  logic                 done_seen = 1'b0;
  logic                 reported = 1'b0;

  assign o_errors   = errors;
  assign o_reported = reported;

  initial $readmemh("uart_input.txt", file_mem);

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s expected %0h, got %0h",
               $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Check failed at %0d ns: %s", $time, what);
    errors++;
    test_errors++;
  endtask

  // ****************************************
  // Sampling on the falling edge
  // ****************************************
  always @(negedge clock) begin
    if (!i_arst_n) begin
      if (run_active) begin  // Abort ends the current test.
        $display("test %0d (reset abort): %0d bytes received, %0d errors",
                 test_num, idx, test_errors);
        test_num++;
      end
      run_active = 1'b0;
      done_seen  = 1'b0;
      idx        = 0;
      exp_sum    = '0;
      check_value("o_valid", 32'd0, 32'(i_valid));
      check_value("o_sum", 32'd0, 32'(i_sum));
    end else begin
      if (!run_active && !done_seen) begin
        run_active  = 1'b1;  // New run starts at byte zero.
        test_errors = 0;
      end
      if (i_valid) begin
        if (idx >= msg_len) begin
          report_failure($sformatf("o_valid pulse after all %0d bytes arrived", msg_len));
        end else begin
          exp_sum = exp_sum + sum_width'(file_mem[idx][7:0]);
          check_value("o_data", 32'(file_mem[idx][7:0]), 32'(i_data));
          check_value("o_sum", 32'(exp_sum), 32'(i_sum));
          idx++;
        end
      end
      if (i_done) begin
        check_value("o_serial", 32'd1, 32'(i_serial));  // Idle line.
        if (!done_seen) begin
          done_seen = 1'b1;
          if (idx < msg_len) begin
            report_failure($sformatf("o_done rose after only %0d of %0d bytes",
                                     idx, msg_len));
          end
          check_value("o_sum", file_mem[msg_len], 32'(i_sum));  // Word after bytes.
          $display("test %0d (full message): %0d bytes received, %0d errors",
                   test_num, idx, test_errors);
          test_num++;
          run_active = 1'b0;
        end
      end
    end
    if (i_finish && !reported) begin
      $display("Summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
      reported = 1'b1;
    end
  end

endmodule

//--- uart_hello.sv
`timescale 1ns/1ps

module uart_hello (
  input  logic        clock,
  input  logic        i_arst_n,
  uart_byte_if.source bus,
  output logic        o_done
);
  import uart_pkg::*;

  logic [idx_width-1:0] idx;   // Current ROM entry.
  logic                 req;   // Registered request level.
  logic                 last;  // Index on final byte.
  logic                 accept;

  // ****************************************
  // Handshake
  // ****************************************
  assign last   = (idx == idx_width'(msg_len - 1)); // Final entry.
  assign accept = req && bus.cts;                   // Byte taken this edge.

  assign bus.data = msg_rom[idx];  // Held while req is high.
  assign bus.req  = req;

  // Walks the ROM once per reset.
  always_ff @(posedge clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      idx    <= '0;
      req    <= 1'b0;
      o_done <= 1'b0;
    end else begin
      if (accept) begin
        if (last) begin
          req    <= 1'b0;    // Message complete.
          o_done <= 1'b1;    // Sticky until reset.
        end else begin
          idx <= idx + 1'b1; // Next byte.
        end
      end else if (!o_done) begin
        req <= 1'b1;         // First clock out of reset.
      end
    end
  end

  // The index stops on the last entry, so the
  // data lines stay put after the message ends.

endmodule

//--- uart_input.txt
// Words 0-11 expected message bytes, word 12 expected running sum,
// word 13 number of abort points, then the bytes received before each reset.
68 65 6C 6C 6F 20
77 6F 72 6C 64 0A
// Sum of the twelve bytes.
00000466
// Abort points.
00000002
00000003
00000007

//--- uart_pkg.sv
package uart_pkg;

  // ****************************************
  // Serial timing
  // ****************************************
  localparam int cycles_per_bit = 3;                 // Clocks per serial bit.
  localparam int cnt_width = $clog2(cycles_per_bit); // Bit-period counter width.
  localparam logic [cnt_width-1:0] cnt_last = cnt_width'(cycles_per_bit - 1); // Last clock.
  localparam logic [cnt_width-1:0] cnt_mid = cnt_width'((cycles_per_bit - 1) / 2); // Mid-bit.

  // ****************************************
  // Message and checksum
  // ****************************************
  localparam int msg_len = 12;                       // Bytes in the message.
  localparam int idx_width = $clog2(msg_len);        // ROM index width.
  localparam int sum_width = 32;                     // Running sum width.

  // "hello world" and a newline.
  localparam logic [7:0] msg_rom [msg_len] = '{
    8'h68, 8'h65, 8'h6C, 8'h6C, 8'h6F, 8'h20,
    8'h77, 8'h6F, 8'h72, 8'h6C, 8'h64, 8'h0A
  };

  // ****************************************
  // FSM states
  // ****************************************
  typedef enum logic [1:0] {
    tx_idle, tx_start, tx_data, tx_stop
  } tx_state_t;

  typedef enum logic [1:0] {
    rx_idle, rx_start, rx_data, rx_stop
  } rx_state_t;

endpackage

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic                           clock,
  input  logic                           i_arst_n,
  input  logic                           i_serial,
  output logic [7:0]                     o_data,
  output logic                           o_valid,
  output logic [uart_pkg::sum_width-1:0] o_sum
);
  import uart_pkg::*;

  rx_state_t            state;     // Frame FSM.
  logic [cnt_width-1:0] cnt;       // Clocks since last sample point.
  logic [2:0]           bit_idx;   // Data bit being sampled.
  logic [7:0]           shift;     // Incoming byte, filled from the top.
  logic                 bit_end;
  logic                 frame_ok;  // Good stop bit seen.

  assign bit_end  = (cnt == cnt_last);
  assign frame_ok = (state == rx_stop) && bit_end && i_serial;

  // ****************************************
  // Frame sequencing
  // ****************************************
  always_ff @(posedge clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= rx_idle;
      cnt     <= '0;
      bit_idx <= '0;
      o_valid <= 1'b0;
      o_sum   <= '0;
    end else begin
      o_valid <= 1'b0;  // Strobe lasts one cycle.
      case (state)
        rx_idle: begin
          if (!i_serial) begin
            cnt   <= cnt_width'(1);  // This edge is the first sample.
            state <= rx_start;
          end
        end
        rx_start: begin
          if (cnt >= cnt_mid) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= i_serial ? rx_idle : rx_data;  // Reject a glitch.
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_data: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= rx_stop;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (bit_end) begin
            cnt   <= '0;
            state <= rx_idle;  // Bad stop drops the frame.
            if (i_serial) begin
              o_valid <= 1'b1;
              o_sum   <= o_sum + sum_width'(shift);
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // Mid-bit samples and the output buffer.
  always_ff @(posedge clock) begin
    if ((state == rx_data) && bit_end) shift <= {i_serial, shift[7:1]};
    if (frame_ok) o_data <= shift;  // Same edge as the strobe.
  end

endmodule

//--- uart_top.sv
`timescale 1ns/1ps

module uart_top (
  input  logic                           clock,
  input  logic                           i_arst_n,
  output logic                           o_serial,
  output logic [7:0]                     o_data,
  output logic                           o_valid,
  output logic                           o_done,
  output logic [uart_pkg::sum_width-1:0] o_sum
);

  // ****************************************
  // Source to transmitter
  // ****************************************
  uart_byte_if byte_bus ();  // Byte handoff.

  logic hello_done;          // Whole message accepted.

  uart_hello hello_inst (
    .clock    (clock),
    .i_arst_n (i_arst_n),
    .bus      (byte_bus),
    .o_done   (hello_done)
  );

  uart_tx tx_inst (
    .clock    (clock),
    .i_arst_n (i_arst_n),
    .bus      (byte_bus),
    .o_serial (o_serial)     // Also the loopback line.
  );

  // ****************************************
  // Loopback receiver
  // ****************************************
  uart_rx rx_inst (
    .clock    (clock),
    .i_arst_n (i_arst_n),
    .i_serial (o_serial),
    .o_data   (o_data),
    .o_valid  (o_valid),
    .o_sum    (o_sum)
  );

  assign o_done = hello_done & byte_bus.idle;  // Last frame fully out.

endmodule

//--- uart_top_sva.sv
`timescale 1ns/1ps

module uart_top_sva (
  input logic                           clock,
  input logic                           i_arst_n,
  input logic                           i_serial,
  input logic                           i_valid,
  input logic                           i_done,
  input logic [uart_pkg::sum_width-1:0] i_sum
);

  int fail_count = 0;  // Failed assertion attempts.

  // ****************************************
  // Strobe and line rules
  // ****************************************
  valid_single: assert property (@(posedge clock) disable iff (!i_arst_n)
    i_valid |=> !i_valid)
    else begin
      $error("o_valid high in two consecutive cycles");
      fail_count++;
    end

  serial_mark_in_reset: assert property (@(posedge clock)
    !i_arst_n |-> i_serial)  // Line rests high.
    else begin
      $error("o_serial low while reset is asserted");
      fail_count++;
    end

  done_sticky: assert property (@(posedge clock) disable iff (!i_arst_n)
    i_done |=> i_done)
    else begin
      $error("o_done dropped before reset");
      fail_count++;
    end

  sum_moves_with_valid: assert property (@(posedge clock) disable iff (!i_arst_n)
    !$stable(i_sum) |-> i_valid)  // Sum and strobe share an edge.
    else begin
      $error("o_sum changed in a cycle without o_valid");
      fail_count++;
    end

endmodule

bind uart_top uart_top_sva sva_inst (
  .clock    (clock),
  .i_arst_n (i_arst_n),
  .i_serial (o_serial),
  .i_valid  (o_valid),
  .i_done   (o_done),
  .i_sum    (o_sum)
);

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic      clock,
  input  logic      i_arst_n,
  uart_byte_if.sink bus,
  output logic      o_serial
);
  import uart_pkg::*;

  tx_state_t            state;    // Frame FSM.
  logic [cnt_width-1:0] cnt;      // Clocks into current bit.
  logic [2:0]           bit_idx;  // Data bit being sent.
  logic [7:0]           shift;    // Outgoing byte, LSB at bit 0.
  logic                 accept;
  logic                 bit_end;

  assign accept  = bus.req && bus.cts;   // Handshake edge.
  assign bit_end = (cnt == cnt_last);    // Last clock of a bit.

  assign bus.cts  = (state == tx_idle);  // Ready only between frames.
  assign bus.idle = (state == tx_idle);

  // ****************************************
  // Frame sequencing
  // ****************************************
  always_ff @(posedge clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= tx_idle;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        tx_idle: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (accept) state <= tx_start;  // Byte latched below.
        end
        tx_start: begin
          if (bit_end) begin
            cnt   <= '0;
            state <= tx_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        tx_data: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= tx_stop;  // Eighth bit done.
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        tx_stop: begin
          if (bit_end) begin
            cnt   <= '0;
            state <= tx_idle;  // cts returns here.
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // Payload shift register.
  always_ff @(posedge clock) begin
    if (accept) begin
      shift <= bus.data;
    end else if ((state == tx_data) && bit_end) begin
      shift <= {1'b0, shift[7:1]};  // Next bit to LSB.
    end
  end

  // ****************************************
  // Line driver
  // ****************************************
  always_comb begin
    case (state)
      tx_start: o_serial = 1'b0;      // Start bit.
      tx_data:  o_serial = shift[0];  // LSB first.
      default:  o_serial = 1'b1;      // Idle and stop are mark.
    endcase
  end

endmodule
